/* src/board_ctrl_consts.svh */
// ======================================================================
// board housekeeping constants
// port widths, reset pulse lengths, debounce and heartbeat timeouts
// ======================================================================

`ifndef BOARD_CTRL_CONSTS_SVH
`define BOARD_CTRL_CONSTS_SVH

// ======================================================================
// widths
// ======================================================================
`define KEY_WIDTH       4    // push keys, active low
`define SW_WIDTH        10   // slide switches
`define LED_PIO_WIDTH   9    // led pio from the processor side
`define STM_WIDTH       28   // trace event word to the hps

// ======================================================================
// reset request pulse lengths, in fpga_clk_50 cycles
// ======================================================================
`define COLD_PULSE_EXT  6
`define WARM_PULSE_EXT  2
`define DEBUG_PULSE_EXT 32

// ======================================================================
// default timeouts at 50 MHz
// ======================================================================
`define DEBOUNCE_TIMEOUT_DEFAULT 50000     // 1 ms key stable time
`define HEARTBEAT_HALF_DEFAULT   25000000  // 0.5 s, so the led blinks at 1 Hz

`endif

/* src/board_ctrl_pkg.sv */
// ======================================================================
// shared types for the board housekeeping logic
// key/switch/led vectors, reset request bits, trace event word,
// pulse generator state
// ======================================================================

`include "board_ctrl_consts.svh"

package board_ctrl_pkg;

    typedef logic [`KEY_WIDTH-1:0]     key_t;      // one bit per push key
    typedef logic [`SW_WIDTH-1:0]      sw_t;
    typedef logic [`LED_PIO_WIDTH-1:0] led_pio_t;

    // declared msb first, so cold lands on bit 0 like the probe source did
    typedef struct packed {
        logic debug;  // bit 2
        logic warm;   // bit 1
        logic cold;   // bit 0
    } reset_req_t;

    // trace event word, msb down
    // pad takes whatever is left of STM_WIDTH above the three fields
    typedef struct packed {
        logic [`STM_WIDTH-`SW_WIDTH-`LED_PIO_WIDTH-`KEY_WIDTH-1:0] pad;
        sw_t      sw;
        led_pio_t led_pio;
        key_t     keys;       // debounced, active low
    } stm_events_t;

    typedef enum logic {
        PULSE_IDLE = 1'b0,    // output high, waiting for a rising request
        PULSE_BUSY = 1'b1     // output low, counting down
    } pulse_state_e;

endpackage

/* src/key_debounce.sv */
// ======================================================================
// push key debouncer
// two-flop synchronizer, then one stable-time counter per key
// ======================================================================

`timescale 1ns/1ns

`include "board_ctrl_consts.svh"

module key_debounce #(
    parameter int unsigned timeout = `DEBOUNCE_TIMEOUT_DEFAULT  // stable samples needed
) (
    input  logic                 fpga_clk_50,
    input  logic                 hps_fpga_reset_n,
    input  board_ctrl_pkg::key_t key,             // raw keys, async to the clock
    output board_ctrl_pkg::key_t debounced_keys
);

    // counter only has to reach timeout-1
    localparam int unsigned cnt_w = (timeout > 1) ? $clog2(timeout) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(timeout - 1);

    board_ctrl_pkg::key_t key_meta;   // first sync stage
    board_ctrl_pkg::key_t key_sync;   // second sync stage, safe to use

    // ==================================================================
    // synchronizer
    // ==================================================================
    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            key_meta <= '1;   // keys idle high
            key_sync <= '1;
        end
        else
        begin
            key_meta <= key;
            key_sync <= key_meta;
        end
    end

    // ==================================================================
    // per-key stable-time filter
    // ==================================================================
    for (genvar i = 0; i < `KEY_WIDTH; i++)
    begin : g_key
        logic [cnt_w-1:0] cnt;      // consecutive samples differing from key_out
        logic             key_out;  // filtered level

        always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
        begin
            if (!hps_fpga_reset_n)
            begin
                cnt     <= '0;
                key_out <= 1'b1;            // released
            end
            else if (key_sync[i] == key_out)
                cnt <= '0;                  // bounce back, start over
            else if (cnt == cnt_last)
            begin
                key_out <= key_sync[i];     // held long enough, take it
                cnt     <= '0;
            end
            else
                cnt <= cnt + 1'b1;
        end

        assign debounced_keys[i] = key_out;
    end

endmodule

/* src/reset_req_regs.sv */
// ======================================================================
// reset request register
// holds the cold/warm/debug request bits written by a strobe
// ======================================================================

`timescale 1ns/1ns

module reset_req_regs (
    input  logic                       fpga_clk_50,
    input  logic                       hps_fpga_reset_n,
    input  logic                       reset_req_wr,    // one-cycle write strobe
    input  board_ctrl_pkg::reset_req_t reset_req_data,
    output board_ctrl_pkg::reset_req_t req              // levels to the pulse generators
);

    // stands in for the probe source on the board
    // a bit must go back to 0 before it can request again
    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
            req <= '0;                      // no request pending
        else if (reset_req_wr)
            req <= reset_req_data;          // whole word loads at once
    end

endmodule

/* src/reset_pulse_gen.sv */
// ======================================================================
// reset request pulse generator
// rising-edge detect on a request level, fixed-length active-low pulse
// ======================================================================

`timescale 1ns/1ns

`include "board_ctrl_consts.svh"

module reset_pulse_gen #(
    parameter int unsigned pulse_ext = `COLD_PULSE_EXT  // low time in cycles
) (
    input  logic fpga_clk_50,
    input  logic hps_fpga_reset_n,
    input  logic req_level,      // request bit from the register block
    output logic reset_req_n     // active-low request to the hps
);

    localparam int unsigned cnt_w = (pulse_ext > 1) ? $clog2(pulse_ext) : 1;
    localparam logic [cnt_w-1:0] cnt_load = cnt_w'(pulse_ext - 1);

    logic                         req_d1;    // registered request
    logic                         req_d2;    // previous sample for the edge compare
    logic                         req_rise;
    board_ctrl_pkg::pulse_state_e state;
    logic [cnt_w-1:0]             cnt;       // cycles left after this one

    // ==================================================================
    // edge detect
    // ==================================================================
    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            req_d1 <= 1'b0;
            req_d2 <= 1'b0;
        end
        else
        begin
            req_d1 <= req_level;
            req_d2 <= req_d1;
        end
    end

    assign req_rise = req_d1 & ~req_d2;   // 0 to 1 only

    // ==================================================================
    // pulse stretcher
    // ==================================================================
    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            state <= board_ctrl_pkg::PULSE_IDLE;
            cnt   <= '0;
        end
        else
        begin
            case (state)
                board_ctrl_pkg::PULSE_IDLE:
                    if (req_rise)
                    begin
                        state <= board_ctrl_pkg::PULSE_BUSY;
                        cnt   <= cnt_load;
                    end
                board_ctrl_pkg::PULSE_BUSY:       // new edges dropped here
                    if (cnt == '0)
                        state <= board_ctrl_pkg::PULSE_IDLE;
                    else
                        cnt <= cnt - 1'b1;
            endcase
        end
    end

    assign reset_req_n = (state != board_ctrl_pkg::PULSE_BUSY);  // low while busy

endmodule

/* src/heartbeat_led.sv */
// ======================================================================
// heartbeat led
// half-period counter toggling led 0 while the fabric is running
// ======================================================================

`timescale 1ns/1ns

`include "board_ctrl_consts.svh"

module heartbeat_led #(
    parameter int unsigned half_period = `HEARTBEAT_HALF_DEFAULT  // cycles per level
) (
    input  logic fpga_clk_50,
    input  logic hps_fpga_reset_n,
    output logic led
);

    localparam int unsigned cnt_w = (half_period > 1) ? $clog2(half_period) : 1;
    localparam logic [cnt_w-1:0] cnt_wrap = cnt_w'(half_period - 1);

    logic [cnt_w-1:0] cnt;

    // first toggle half_period edges after reset goes away
    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            cnt <= '0;
            led <= 1'b0;            // led off in reset
        end
        else if (cnt == cnt_wrap)
        begin
            cnt <= '0;              // wrap
            led <= ~led;
        end
        else
            cnt <= cnt + 1'b1;
    end

endmodule

/* src/board_ctrl_top.sv */
// ======================================================================
// board housekeeping top level
// key debounce, reset request pulses, heartbeat led, trace event word
// ======================================================================

`timescale 1ns/1ns

`include "board_ctrl_consts.svh"

module board_ctrl_top #(
    parameter int unsigned debounce_timeout = `DEBOUNCE_TIMEOUT_DEFAULT,
    parameter int unsigned heartbeat_half   = `HEARTBEAT_HALF_DEFAULT
) (
    input  logic                        fpga_clk_50,
    input  logic                        hps_fpga_reset_n,
    input  board_ctrl_pkg::key_t        key,               // active low
    input  board_ctrl_pkg::sw_t         sw,
    input  board_ctrl_pkg::led_pio_t    led_pio,           // processor led value
    input  logic                        reset_req_wr,
    input  board_ctrl_pkg::reset_req_t  reset_req_data,
    output logic [`LED_PIO_WIDTH:0]     ledr,              // 9..1 pio, 0 heartbeat
    output board_ctrl_pkg::key_t        debounced_keys,    // to the button pio
    output board_ctrl_pkg::stm_events_t stm_hw_events,
    output logic                        cold_reset_req_n,
    output logic                        warm_reset_req_n,
    output logic                        debug_reset_req_n
);

    board_ctrl_pkg::reset_req_t req;        // held request levels
    logic                       heartbeat;

    // ==================================================================
    // keys
    // ==================================================================
    key_debounce #(
        .timeout (debounce_timeout)
    ) u_key_debounce (
        .fpga_clk_50      (fpga_clk_50),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .key              (key),
        .debounced_keys   (debounced_keys)
    );

    // ==================================================================
    // reset requests
    // ==================================================================
    reset_req_regs u_reset_req_regs (
        .fpga_clk_50      (fpga_clk_50),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .reset_req_wr     (reset_req_wr),
        .reset_req_data   (reset_req_data),
        .req              (req)
    );

    reset_pulse_gen #(
        .pulse_ext (`COLD_PULSE_EXT)
    ) u_pulse_cold (
        .fpga_clk_50      (fpga_clk_50),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .req_level        (req.cold),
        .reset_req_n      (cold_reset_req_n)
    );

    reset_pulse_gen #(
        .pulse_ext (`WARM_PULSE_EXT)
    ) u_pulse_warm (
        .fpga_clk_50      (fpga_clk_50),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .req_level        (req.warm),
        .reset_req_n      (warm_reset_req_n)
    );

    reset_pulse_gen #(
        .pulse_ext (`DEBUG_PULSE_EXT)
    ) u_pulse_debug (
        .fpga_clk_50      (fpga_clk_50),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .req_level        (req.debug),
        .reset_req_n      (debug_reset_req_n)
    );

    // ==================================================================
    // heartbeat, leds and trace events
    // ==================================================================
    heartbeat_led #(
        .half_period (heartbeat_half)
    ) u_heartbeat_led (
        .fpga_clk_50      (fpga_clk_50),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .led              (heartbeat)
    );

    assign ledr = {led_pio, heartbeat};

    // event word is pure wiring
    assign stm_hw_events.pad     = '0;
    assign stm_hw_events.sw      = sw;
    assign stm_hw_events.led_pio = led_pio;
    assign stm_hw_events.keys    = debounced_keys;

endmodule

/* dv/board_ctrl_tb.sv */
// ======================================================================
// testbench for the board housekeeping top level
// clock, reset, seeded random stimulus, cycle model, compare tasks,
// watchdog
// ======================================================================

`timescale 1ns/1ns

`include "board_ctrl_consts.svh"

module board_ctrl_tb;

    localparam int clk_period  = 20;
    localparam int debounce_t  = 16;
    localparam int hb_half     = 50;
    localparam int pad_w       = `STM_WIDTH - `SW_WIDTH - `LED_PIO_WIDTH - `KEY_WIDTH;
    localparam int n_rounds    = 12;   // glitch bursts plus one level change each
    localparam int n_writes    = 60;
    localparam int n_events    = 50;
    localparam int tail_cycles = 120;
    localparam int test_cycles = 8 + n_rounds * (3 * (15 + 4) + 20)
                                 + n_writes * (1 + 40) + 41 + n_events + tail_cycles;

    logic                        fpga_clk_50 = 1'b0;
    logic                        hps_fpga_reset_n;
    board_ctrl_pkg::key_t        key;
    board_ctrl_pkg::sw_t         sw;
    board_ctrl_pkg::led_pio_t    led_pio;
    logic                        reset_req_wr;
    board_ctrl_pkg::reset_req_t  reset_req_data;
    logic [`LED_PIO_WIDTH:0]     ledr;
    board_ctrl_pkg::key_t        debounced_keys;
    board_ctrl_pkg::stm_events_t stm_hw_events;
    logic                        cold_reset_req_n;
    logic                        warm_reset_req_n;
    logic                        debug_reset_req_n;

    // model state
    board_ctrl_pkg::key_t m_meta, m_sync, m_keys;
    int                   m_run [`KEY_WIDTH];   // consecutive differing samples
    logic [2:0]           m_req_v, m_d1, m_d2;  // bit 0 cold, 1 warm, 2 debug
    int                   m_left [3];           // low cycles still to come
    logic                 m_hb;
    int                   m_hb_cnt;

    int                   seed;
    int                   rnd;
    int                   cycle;                // negedges since reset release
    int                   hb_last;
    logic                 hb_prev;
    int                   low_len [3];
    board_ctrl_pkg::key_t key_level;            // level the keys rest at

    board_ctrl_top #(
        .debounce_timeout (debounce_t),
        .heartbeat_half   (hb_half)
    ) u_board_ctrl_top (
        .fpga_clk_50       (fpga_clk_50),
        .hps_fpga_reset_n  (hps_fpga_reset_n),
        .key               (key),
        .sw                (sw),
        .led_pio           (led_pio),
        .reset_req_wr      (reset_req_wr),
        .reset_req_data    (reset_req_data),
        .ledr              (ledr),
        .debounced_keys    (debounced_keys),
        .stm_hw_events     (stm_hw_events),
        .cold_reset_req_n  (cold_reset_req_n),
        .warm_reset_req_n  (warm_reset_req_n),
        .debug_reset_req_n (debug_reset_req_n)
    );

    always #(clk_period / 2) fpga_clk_50 = ~fpga_clk_50;

    function automatic int pulse_len_of(input int g);
        case (g)
            0:       return `COLD_PULSE_EXT;
            1:       return `WARM_PULSE_EXT;
            default: return `DEBUG_PULSE_EXT;
        endcase
    endfunction

    // ==================================================================
    // reference model, one step per rising edge
    // ==================================================================
    always @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            m_meta   = '1;
            m_sync   = '1;
            m_keys   = '1;        // keys released
            m_req_v  = '0;
            m_d1     = '0;
            m_d2     = '0;
            m_hb     = 1'b0;
            m_hb_cnt = 0;
            for (int i = 0; i < `KEY_WIDTH; i++)
                m_run[i] = 0;
            for (int g = 0; g < 3; g++)
                m_left[g] = 0;
        end
        else
        begin
            // flip after debounce_t samples that differ from the output
            for (int i = 0; i < `KEY_WIDTH; i++)
            begin
                if (m_sync[i] != m_keys[i])
                begin
                    m_run[i] = m_run[i] + 1;
                    if (m_run[i] == debounce_t)
                    begin
                        m_keys[i] = m_sync[i];
                        m_run[i]  = 0;
                    end
                end
                else
                    m_run[i] = 0;     // back to the output level
            end
            m_sync = m_meta;          // two-cycle sampling delay
            m_meta = key;

            // low two edges after req rises, edges while low are dropped
            for (int g = 0; g < 3; g++)
            begin
                if (m_left[g] > 0)
                    m_left[g] = m_left[g] - 1;
                else if (m_d1[g] && !m_d2[g])
                    m_left[g] = pulse_len_of(g);
            end
            m_d2 = m_d1;
            m_d1 = m_req_v;
            if (reset_req_wr)
                m_req_v = reset_req_data;

            m_hb_cnt = m_hb_cnt + 1;
            if (m_hb_cnt == hb_half)
            begin
                m_hb     = ~m_hb;
                m_hb_cnt = 0;
            end
        end
    end

    // ==================================================================
    // compare tasks
    // ==================================================================
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_keys(input board_ctrl_pkg::key_t got, input board_ctrl_pkg::key_t exp);
        if (got !== exp)
            report_failure($sformatf("Fail debounced_keys: got %h expected %h", got, exp));
    endtask

    task automatic check_events(input board_ctrl_pkg::stm_events_t got,
                                input board_ctrl_pkg::stm_events_t exp);
        if (got !== exp)
            report_failure($sformatf("Fail stm_hw_events: got %h expected %h", got, exp));
    endtask

    task automatic check_reset_n(input bit got, input bit exp, input string name);
        if (got !== exp)
            report_failure($sformatf("Fail %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_led(input logic [`LED_PIO_WIDTH:0] got,
                             input logic [`LED_PIO_WIDTH:0] exp);
        if (got !== exp)
            report_failure($sformatf("Fail ledr: got %h expected %h", got, exp));
    endtask

    // falling edge, outputs settled, compare before new inputs go out
    task automatic next_cycle();
        logic [2:0]                  rst_vec;
        board_ctrl_pkg::stm_events_t exp_ev;
        @(negedge fpga_clk_50);
        cycle = cycle + 1;
        exp_ev = {{pad_w{1'b0}}, sw, led_pio, m_keys};    // pad, sw, pio, keys
        check_keys(debounced_keys, m_keys);
        check_events(stm_hw_events, exp_ev);
        check_led(ledr, {led_pio, m_hb});
        check_reset_n(cold_reset_req_n, m_left[0] == 0, "cold_reset_req_n");
        check_reset_n(warm_reset_req_n, m_left[1] == 0, "warm_reset_req_n");
        check_reset_n(debug_reset_req_n, m_left[2] == 0, "debug_reset_req_n");

        // heartbeat period, measured on the pin
        if (ledr[0] !== hb_prev)
        begin
            if (cycle - hb_last != hb_half)
                report_failure($sformatf("Fail heartbeat interval: got %h expected %h",
                                         cycle - hb_last, hb_half));
            hb_last = cycle;
            hb_prev = ledr[0];
        end

        // low time of each finished pulse
        rst_vec = {debug_reset_req_n, warm_reset_req_n, cold_reset_req_n};
        for (int g = 0; g < 3; g++)
        begin
            if (!rst_vec[g])
                low_len[g] = low_len[g] + 1;
            else if (low_len[g] != 0)
            begin
                if (low_len[g] != pulse_len_of(g))
                    report_failure($sformatf("Fail pulse length %0d: got %h expected %h",
                                             g, low_len[g], pulse_len_of(g)));
                low_len[g] = 0;
            end
        end
    endtask

    task automatic key_glitch();
        board_ctrl_pkg::key_t mask;
        int                   len;
        rnd  = $random(seed);
        mask = rnd[3:0];
        if (mask == '0)
            mask = 4'h1;
        len = 1 + ($unsigned(rnd) % 15);     // always shorter than debounce_t
        key = key_level ^ mask;
        repeat (len) next_cycle();
        key = key_level;
        repeat (4) next_cycle();             // let the return reach the filter
        check_keys(debounced_keys, key_level);
    endtask

    task automatic key_level_change();
        board_ctrl_pkg::key_t new_level;
        bit                   seen;
        seen      = 1'b0;
        rnd       = $random(seed);
        new_level = rnd[3:0];
        if (new_level == key_level)
            new_level = ~key_level;
        key = new_level;
        for (int w = 1; w <= debounce_t + 4; w++)
        begin
            next_cycle();
            if (!seen && debounced_keys === new_level)
            begin
                seen = 1'b1;
                if (w < debounce_t)
                    report_failure("debounced keys changed before the stable time ran out");
            end
        end
        if (!seen)
            report_failure("debounced keys did not take a held key level in time");
        key_level = new_level;
    endtask

    // ==================================================================
    // watchdog
    // ==================================================================
    initial
    begin
        #((test_cycles + 2000) * clk_period);
        report_failure("watchdog timeout, the tests did not finish in time");
    end

    // ==================================================================
    // stimulus
    // ==================================================================
    initial
    begin
        seed             = 42;
        hps_fpga_reset_n = 1'b0;
        key              = '1;
        sw               = '0;
        led_pio          = '0;
        reset_req_wr     = 1'b0;
        reset_req_data   = '0;
        key_level        = '1;
        cycle            = 0;
        hb_last          = 0;
        hb_prev          = 1'b0;
        for (int g = 0; g < 3; g++)
            low_len[g] = 0;

        repeat (8) @(negedge fpga_clk_50);
        hps_fpga_reset_n = 1'b1;            // released on a falling edge

        // state straight out of reset
        check_keys(debounced_keys, 4'hf);
        check_reset_n(cold_reset_req_n, 1'b1, "cold_reset_req_n");
        check_reset_n(warm_reset_req_n, 1'b1, "warm_reset_req_n");
        check_reset_n(debug_reset_req_n, 1'b1, "debug_reset_req_n");
        check_led(ledr, {led_pio, 1'b0});

        for (int n = 0; n < n_rounds; n++)
        begin
            repeat (3) key_glitch();
            key_level_change();
        end

        // random request writes, some land while a generator is busy
        for (int n = 0; n < n_writes; n++)
        begin
            rnd            = $random(seed);
            reset_req_data = rnd[2:0];
            reset_req_wr   = 1'b1;
            next_cycle();
            reset_req_wr   = 1'b0;
            repeat ($unsigned(rnd >>> 8) % 41) next_cycle();
        end
        reset_req_data = '0;
        reset_req_wr   = 1'b1;
        next_cycle();
        reset_req_wr   = 1'b0;
        repeat (40) next_cycle();           // drain the longest pulse

        for (int n = 0; n < n_events; n++)
        begin
            rnd     = $random(seed);
            sw      = rnd[9:0];
            led_pio = rnd[18:10];
            next_cycle();
        end

        repeat (tail_cycles) next_cycle();  // a few more heartbeat periods

        $display("All tests passed");
        $finish;
    end

endmodule

/* files.f */
+incdir+src
src/board_ctrl_pkg.sv
src/key_debounce.sv
src/reset_req_regs.sv
src/reset_pulse_gen.sv
src/heartbeat_led.sv
src/board_ctrl_top.sv
dv/board_ctrl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile with verilator and run the board housekeeping testbench
# exit status is 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing -f files.f --top-module board_ctrl_tb \
    -o board_ctrl_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/board_ctrl_sim > sim.log 2>&1 || true
cat sim.log

grep -q "^All tests passed$" sim.log \
    && { echo "simulation PASSED"; exit 0; } \
    || { echo "simulation FAILED"; exit 1; }
